// File: build.f
+incdir+include
verilog/rx_mac_pkg.sv
verilog/xgmii_decoder.sv
verilog/frame_checker.sv
verilog/frame_store.sv
verilog/axis_egress.sv
verilog/rx_mac.sv
dv/rx_mac_tb.sv

// File: include/rx_mac_tb_frames.svh
`ifndef RX_MAC_TB_FRAMES_SVH
`define RX_MAC_TB_FRAMES_SVH

// FCS over the first n frame bytes, reflected CRC-32 inverted at the end
function automatic logic [31:0] fcs_of_payload(input int n);
    logic [31:0] c;
    c = 32'hFFFFFFFF;
    for (int i = 0; i < n; i++) begin
        c = c ^ {24'd0, frame_bytes[i]};
        for (int k = 0; k < 8; k++) begin
            if (c[0]) begin
                c = (c >> 1) ^ 32'hEDB88320;
            end else begin
                c = c >> 1;
            end
        end
    end
    return ~c;
endfunction

// random payload plus FCS, low byte first; good frames also queue their beats
task automatic build_frame(input row_t r);
    logic [31:0] rnd;
    logic [31:0] fcs;
    logic [31:0] data;
    logic [3:0]  keep;
    int          n;
    n = int'(r.len);
    frame_bytes.delete();
    for (int i = 0; i < n - 4; i++) begin
        rnd = $urandom();
        frame_bytes.push_back(rnd[7:0]);
    end
    fcs = fcs_of_payload(n - 4);
    if (r.fcs_bad) begin
        fcs[0] = ~fcs[0];
    end
    for (int i = 0; i < 4; i++) begin
        frame_bytes.push_back(fcs[8*i +: 8]);
    end
    if (r.exp_kind == KIND_OK) begin
        for (int i = 0; i < n; i += 4) begin
            data = '0;
            keep = '0;
            for (int j = 0; j < 4; j++) begin
                if (i + j < n) begin
                    data[8*j +: 8] = frame_bytes[i + j];
                    keep[j] = 1'b1;
                end
            end
            exp_data.push_back(data);
            exp_keep.push_back(keep);
            exp_last.push_back(i + 4 >= n);
        end
    end
endtask

`endif

// File: dv/rx_mac_tb.sv
`timescale 1ns/10ps

module rx_mac_tb;
    import rx_mac_pkg::*;

    typedef struct packed {
        logic [11:0] len;
        logic        fcs_bad;
        logic [2:0]  err_lane;
        logic        bad_pre;
        logic        rdy_rand;
        logic [2:0]  exp_kind;
    } row_t;

    // expected status as {frame_valid, frame_error, crc_error}
    localparam logic [2:0] KIND_OK  = 3'b100;
    localparam logic [2:0] KIND_ERR = 3'b010;
    localparam logic [2:0] KIND_CRC = 3'b011;
    localparam logic [2:0] NO_LANE  = 3'd7;
    localparam int NUM_ROWS = 15;

    logic        rx_clk;
    logic        rx_rst;
    logic [31:0] in_xgmii_data;
    logic [3:0]  in_xgmii_ctl;
    logic        out_xgmii_pcs_ready;
    logic [31:0] out_master_rx_tdata;
    logic [3:0]  out_master_rx_tkeep;
    logic        out_master_rx_tvalid;
    logic        out_master_rx_tlast;
    logic        in_master_rx_tready;
    logic        frame_valid;
    logic        frame_error;
    logic        crc_error;

    row_t        table_rows [NUM_ROWS];
    logic [7:0]  frame_bytes[$];
    logic [31:0] exp_data[$];
    logic [3:0]  exp_keep[$];
    logic        exp_last[$];
    int          exp_cycle[$];
    logic [2:0]  exp_status[$];
    int          cyc = 0;
    int          cycle_limit = 0;
    int          word_idx = 0;
    int          event_idx = 0;
    logic        rdy_rand;

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "%s", what);
    endtask

    `include "rx_mac_tb_frames.svh"

    task automatic load_table();
        table_rows[0]  = '{12'd64,   1'b0, NO_LANE, 1'b0, 1'b0, KIND_OK};
        table_rows[1]  = '{12'd65,   1'b0, NO_LANE, 1'b0, 1'b0, KIND_OK};
        table_rows[2]  = '{12'd66,   1'b0, NO_LANE, 1'b0, 1'b0, KIND_OK};
        table_rows[3]  = '{12'd67,   1'b0, NO_LANE, 1'b0, 1'b0, KIND_OK};
        table_rows[4]  = '{12'd1518, 1'b0, NO_LANE, 1'b0, 1'b0, KIND_OK};
        table_rows[5]  = '{12'd64,   1'b1, NO_LANE, 1'b0, 1'b0, KIND_CRC};
        // good frame right after a rewind
        table_rows[6]  = '{12'd70,   1'b0, NO_LANE, 1'b0, 1'b0, KIND_OK};
        table_rows[7]  = '{12'd63,   1'b0, NO_LANE, 1'b0, 1'b0, KIND_ERR};
        table_rows[8]  = '{12'd1519, 1'b0, NO_LANE, 1'b0, 1'b0, KIND_ERR};
        table_rows[9]  = '{12'd72,   1'b0, 3'd2,    1'b0, 1'b0, KIND_ERR};
        table_rows[10] = '{12'd64,   1'b0, NO_LANE, 1'b1, 1'b0, KIND_ERR};
        table_rows[11] = '{12'd68,   1'b0, NO_LANE, 1'b0, 1'b0, KIND_OK};
        table_rows[12] = '{12'd200,  1'b0, NO_LANE, 1'b0, 1'b1, KIND_OK};
        table_rows[13] = '{12'd131,  1'b0, NO_LANE, 1'b0, 1'b1, KIND_OK};
        table_rows[14] = '{12'd1518, 1'b0, NO_LANE, 1'b0, 1'b1, KIND_OK};
    endtask

    // terminate in lane 0 closes on the held word, otherwise the tail costs a cycle
    task automatic send_frame(input row_t r);
        logic [7:0]  lane_b[$];
        logic        lane_c[$];
        logic [31:0] d;
        logic [3:0]  c;
        int          n;
        int          drive_cyc;
        n = int'(r.len);
        for (int i = 0; i < n; i++) begin
            if (r.err_lane != NO_LANE && i == 20 + int'(r.err_lane)) begin
                lane_b.push_back(XGMII_ERROR);
                lane_c.push_back(1'b1);
            end else begin
                lane_b.push_back(frame_bytes[i]);
                lane_c.push_back(1'b0);
            end
        end
        lane_b.push_back(XGMII_TERMINATE);
        lane_c.push_back(1'b1);
        while (lane_b.size() % 4 != 0) begin
            lane_b.push_back(XGMII_IDLE);
            lane_c.push_back(1'b1);
        end
        @(posedge rx_clk);
        rdy_rand      <= r.rdy_rand;
        in_xgmii_data <= {PREAMBLE_BYTE, PREAMBLE_BYTE, PREAMBLE_BYTE, XGMII_START};
        in_xgmii_ctl  <= 4'b0001;
        @(posedge rx_clk);
        in_xgmii_data <= {r.bad_pre ? PREAMBLE_BYTE : SFD_BYTE, {3{PREAMBLE_BYTE}}};
        in_xgmii_ctl  <= 4'b0000;
        if (r.bad_pre) begin
            exp_cycle.push_back(cyc + 3);
            exp_status.push_back(r.exp_kind);
        end
        drive_cyc = cyc;
        for (int w = 0; w < lane_b.size() / 4; w++) begin
            for (int j = 0; j < 4; j++) begin
                d[8*j +: 8] = lane_b[4*w + j];
                c[j] = lane_c[4*w + j];
            end
            @(posedge rx_clk);
            in_xgmii_data <= d;
            in_xgmii_ctl  <= c;
            drive_cyc = cyc;
        end
        if (!r.bad_pre) begin
            exp_cycle.push_back(drive_cyc + ((n % 4 == 0) ? 3 : 4));
            exp_status.push_back(r.exp_kind);
        end
        repeat (4) begin
            @(posedge rx_clk);
            in_xgmii_data <= {4{XGMII_IDLE}};
            in_xgmii_ctl  <= 4'hF;
        end
    endtask

    rx_mac #(
        .FIFO_DEPTH (512)
    ) rx_mac_inst (
        .rx_clk               (rx_clk),
        .rx_rst               (rx_rst),
        .in_xgmii_data        (in_xgmii_data),
        .in_xgmii_ctl         (in_xgmii_ctl),
        .out_xgmii_pcs_ready  (out_xgmii_pcs_ready),
        .out_master_rx_tdata  (out_master_rx_tdata),
        .out_master_rx_tkeep  (out_master_rx_tkeep),
        .out_master_rx_tvalid (out_master_rx_tvalid),
        .out_master_rx_tlast  (out_master_rx_tlast),
        .in_master_rx_tready  (in_master_rx_tready),
        .frame_valid          (frame_valid),
        .frame_error          (frame_error),
        .crc_error            (crc_error)
    );

    initial begin
        rx_clk = 1'b0;
        forever #4 rx_clk = ~rx_clk;
    end

    always @(posedge rx_clk) begin : ready_drive
        logic [31:0] rnd;
        if (rdy_rand) begin
            rnd = $urandom();
            in_master_rx_tready <= rnd[0];
        end else begin
            in_master_rx_tready <= 1'b1;
        end
    end

    always @(posedge rx_clk) begin : monitor
        logic [31:0] mask;
        logic        stall_q;
        logic [36:0] stall_word;
        cyc <= cyc + 1;
        if (rx_rst) begin
            for (int j = 0; j < 4; j++) begin
                mask[8*j +: 8] = {8{out_master_rx_tkeep[j]}};
            end
            if (stall_q) begin
                check("tvalid held under back-pressure", 64'(1), 64'(out_master_rx_tvalid));
                check("word held under back-pressure", 64'(stall_word),
                      64'({out_master_rx_tdata, out_master_rx_tkeep, out_master_rx_tlast}));
            end
            if (out_master_rx_tvalid && in_master_rx_tready) begin
                if (exp_data.size() == 0) begin
                    report_failure("an output word arrived with no good frame pending");
                end
                check($sformatf("word %0d tdata", word_idx), 64'(exp_data[0] & mask),
                      64'(out_master_rx_tdata & mask));
                check($sformatf("word %0d tkeep", word_idx), 64'(exp_keep[0]),
                      64'(out_master_rx_tkeep));
                check($sformatf("word %0d tlast", word_idx), 64'(exp_last[0]),
                      64'(out_master_rx_tlast));
                void'(exp_data.pop_front());
                void'(exp_keep.pop_front());
                void'(exp_last.pop_front());
                word_idx++;
            end
            if (frame_valid || frame_error || crc_error) begin
                if (exp_status.size() == 0) begin
                    report_failure("a status pulse arrived with no frame pending");
                end
                check($sformatf("frame %0d status cycle", event_idx), 64'(exp_cycle[0]),
                      64'(cyc));
                check($sformatf("frame %0d status", event_idx), 64'(exp_status[0]),
                      64'({frame_valid, frame_error, crc_error}));
                void'(exp_cycle.pop_front());
                void'(exp_status.pop_front());
                event_idx++;
            end else if (exp_cycle.size() != 0 && cyc > exp_cycle[0]) begin
                report_failure("an expected status pulse never arrived");
            end
            stall_q    = out_master_rx_tvalid && !in_master_rx_tready;
            stall_word = {out_master_rx_tdata, out_master_rx_tkeep, out_master_rx_tlast};
        end else begin
            stall_q = 1'b0;
        end
    end

    initial begin
        wait (cycle_limit > 0);
        while (cyc < cycle_limit) begin
            @(posedge rx_clk);
        end
        $display("run stopped after %0d cycles with frames still outstanding", cyc);
        $display("CHECKS FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        int total_words;
        void'($urandom(60));
        rx_rst              = 1'b0;
        in_xgmii_data       = {4{XGMII_IDLE}};
        in_xgmii_ctl        = 4'hF;
        in_master_rx_tready = 1'b1;
        rdy_rand            = 1'b0;
        load_table();
        total_words = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total_words += 6 + (int'(table_rows[r].len) + 4) / 4;
        end
        cycle_limit = (total_words + 50 * NUM_ROWS) * 2;
        repeat (3) @(posedge rx_clk);
        rx_rst <= 1'b1;
        repeat (4) @(posedge rx_clk);
        check("pcs ready after reset", 64'(1), 64'(out_xgmii_pcs_ready));
        for (int r = 0; r < NUM_ROWS; r++) begin
            build_frame(table_rows[r]);
            send_frame(table_rows[r]);
        end
        @(posedge rx_clk);
        rdy_rand <= 1'b0;
        while (exp_data.size() != 0 || exp_status.size() != 0) begin
            @(posedge rx_clk);
        end
        repeat (4) @(posedge rx_clk);
        check("output idle after last frame", 64'(0), 64'(out_master_rx_tvalid));
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the receive MAC testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module rx_mac_tb -o rx_mac_sim

./obj_dir/rx_mac_sim

// File: verilog/axis_egress.sv
`timescale 1ns/10ps

module axis_egress (
    input  logic                 rx_clk,
    input  logic                 rx_rst,
    input  rx_mac_pkg::rx_beat_t rd_beat,
    input  logic                 rd_ready,
    output logic                 rd_pop,
    output logic [31:0]          out_master_rx_tdata,
    output logic [3:0]           out_master_rx_tkeep,
    output logic                 out_master_rx_tvalid,
    output logic                 out_master_rx_tlast,
    input  logic                 in_master_rx_tready
);
    logic load;

    // refill when the stage is empty or its word is taken this cycle
    assign load   = rd_ready && (!out_master_rx_tvalid || in_master_rx_tready);
    assign rd_pop = load;

    always_ff @(posedge rx_clk) begin
        if (!rx_rst) begin
            out_master_rx_tvalid <= 1'b0;
        end else if (load) begin
            out_master_rx_tvalid <= 1'b1;
        end else if (in_master_rx_tready) begin
            out_master_rx_tvalid <= 1'b0;
        end
    end

    // word holds while tready is low
    always_ff @(posedge rx_clk) begin
        if (load) begin
            out_master_rx_tdata <= rd_beat.data;
            out_master_rx_tkeep <= rd_beat.keep;
            out_master_rx_tlast <= rd_beat.last;
        end
    end

endmodule

// File: verilog/frame_checker.sv
`timescale 1ns/10ps

module frame_checker (
    input  logic                       rx_clk,
    input  logic                       rx_rst,
    input  rx_mac_pkg::rx_beat_t       beat,
    input  logic                       beat_valid,
    input  rx_mac_pkg::frame_end_t     frame_end,
    input  logic                       overflow,
    output rx_mac_pkg::frame_verdict_t verdict
);
    import rx_mac_pkg::*;

    // the register shifts right, so it ends on the residue with its bits reversed
    localparam logic [31:0] RESIDUE_REFL = {<<{CRC_RESIDUE}};

    logic [31:0] crc_q;
    logic [31:0] crc_next;
    logic        crc_ok;
    logic        frame_bad;

    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc ^ {24'd0, b};
        for (int k = 0; k < 8; k++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    // lanes are folded in order, lane 0 first
    always_comb begin
        crc_next = crc_q;
        for (int i = 0; i < LANES; i++) begin
            if (beat_valid && beat.keep[i]) begin
                crc_next = crc_byte(crc_next, beat.data[8*i +: 8]);
            end
        end
    end

    // running CRC over the FCS bytes lands on the fixed residue
    assign crc_ok    = crc_next == RESIDUE_REFL;
    assign frame_bad = frame_end.code_err | frame_end.len_err | overflow;

    always_ff @(posedge rx_clk) begin
        if (!rx_rst) begin
            crc_q   <= CRC_INIT;
            verdict <= '0;
        end else begin
            verdict <= '0;
            if (frame_end.done) begin
                crc_q           <= CRC_INIT;
                verdict.commit  <= !frame_bad && crc_ok;
                verdict.discard <= frame_bad || !crc_ok;
                verdict.crc_bad <= !frame_bad && !crc_ok;
            end else if (beat_valid) begin
                crc_q <= crc_next;
            end
        end
    end

endmodule

// File: verilog/frame_store.sv
`timescale 1ns/10ps

module frame_store #(
    parameter int FIFO_DEPTH = 512
) (
    input  logic                       rx_clk,
    input  logic                       rx_rst,
    input  rx_mac_pkg::rx_beat_t       wr_beat,
    input  logic                       wr_valid,
    input  rx_mac_pkg::frame_verdict_t verdict,
    output logic                       overflow,
    output rx_mac_pkg::rx_beat_t       rd_beat,
    output logic                       rd_ready,
    input  logic                       rd_pop
);
    import rx_mac_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    rx_beat_t mem [FIFO_DEPTH];

    // one extra bit on each pointer tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] cmt_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        ovf_q;
    logic        wr_en;

    assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // once a frame has overflowed, the rest of it is dropped
    assign wr_en    = wr_valid && !full && !ovf_q;
    assign overflow = ovf_q || (wr_valid && full);

    // only committed words are visible to the reader
    assign rd_ready = rd_ptr != cmt_ptr;
    assign rd_beat  = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge rx_clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= wr_beat;
        end
    end

    always_ff @(posedge rx_clk) begin
        if (!rx_rst) begin
            wr_ptr  <= '0;
            cmt_ptr <= '0;
        end else begin
            if (verdict.discard) begin
                wr_ptr <= cmt_ptr;
            end else if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (verdict.commit) begin
                cmt_ptr <= wr_ptr;
            end
        end
    end

    always_ff @(posedge rx_clk) begin
        if (!rx_rst) begin
            rd_ptr <= '0;
        end else if (rd_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge rx_clk) begin
        if (!rx_rst) begin
            ovf_q <= 1'b0;
        end else if (verdict.commit || verdict.discard) begin
            ovf_q <= 1'b0;
        end else if (wr_valid && full) begin
            ovf_q <= 1'b1;
        end
    end

endmodule

// File: verilog/rx_mac.sv
`timescale 1ns/10ps

module rx_mac #(
    parameter int FIFO_DEPTH = 512
) (
    input  logic        rx_clk,
    input  logic        rx_rst,
    input  logic [31:0] in_xgmii_data,
    input  logic [3:0]  in_xgmii_ctl,
    output logic        out_xgmii_pcs_ready,
    output logic [31:0] out_master_rx_tdata,
    output logic [3:0]  out_master_rx_tkeep,
    output logic        out_master_rx_tvalid,
    output logic        out_master_rx_tlast,
    input  logic        in_master_rx_tready,
    output logic        frame_valid,
    output logic        frame_error,
    output logic        crc_error
);
    import rx_mac_pkg::*;

    rx_beat_t       beat;
    logic           beat_valid;
    frame_end_t     frame_end;
    frame_verdict_t verdict;
    logic           overflow;
    rx_beat_t       rd_beat;
    logic           rd_ready;
    logic           rd_pop;

    always_ff @(posedge rx_clk) begin
        if (!rx_rst) begin
            out_xgmii_pcs_ready <= 1'b0;
        end else begin
            out_xgmii_pcs_ready <= 1'b1;
        end
    end

    // status pulses follow the registered verdict
    assign frame_valid = verdict.commit;
    assign frame_error = verdict.discard;
    assign crc_error   = verdict.crc_bad;

    xgmii_decoder xgmii_decoder_inst (
        .rx_clk        (rx_clk),
        .rx_rst        (rx_rst),
        .in_xgmii_data (in_xgmii_data),
        .in_xgmii_ctl  (in_xgmii_ctl),
        .beat          (beat),
        .beat_valid    (beat_valid),
        .frame_end     (frame_end)
    );

    frame_checker frame_checker_inst (
        .rx_clk     (rx_clk),
        .rx_rst     (rx_rst),
        .beat       (beat),
        .beat_valid (beat_valid),
        .frame_end  (frame_end),
        .overflow   (overflow),
        .verdict    (verdict)
    );

    frame_store #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) frame_store_inst (
        .rx_clk   (rx_clk),
        .rx_rst   (rx_rst),
        .wr_beat  (beat),
        .wr_valid (beat_valid),
        .verdict  (verdict),
        .overflow (overflow),
        .rd_beat  (rd_beat),
        .rd_ready (rd_ready),
        .rd_pop   (rd_pop)
    );

    axis_egress axis_egress_inst (
        .rx_clk               (rx_clk),
        .rx_rst               (rx_rst),
        .rd_beat              (rd_beat),
        .rd_ready             (rd_ready),
        .rd_pop               (rd_pop),
        .out_master_rx_tdata  (out_master_rx_tdata),
        .out_master_rx_tkeep  (out_master_rx_tkeep),
        .out_master_rx_tvalid (out_master_rx_tvalid),
        .out_master_rx_tlast  (out_master_rx_tlast),
        .in_master_rx_tready  (in_master_rx_tready)
    );

endmodule

// File: verilog/rx_mac_pkg.sv
package rx_mac_pkg;

    // XGMII control characters
    localparam logic [7:0] XGMII_IDLE      = 8'h07;
    localparam logic [7:0] XGMII_START     = 8'hFB;
    localparam logic [7:0] XGMII_TERMINATE = 8'hFD;
    localparam logic [7:0] XGMII_ERROR     = 8'hFE;

    // data bytes that open a frame
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;

    // frame length limits, FCS included
    localparam int MIN_FRAME_SIZE = 64;
    localparam int MAX_FRAME_SIZE = 1518;

    // reflected CRC-32
    localparam logic [31:0] CRC_POLY    = 32'hEDB88320;
    localparam logic [31:0] CRC_INIT    = 32'hFFFFFFFF;
    localparam logic [31:0] CRC_RESIDUE = 32'hC704DD7B;

    localparam int LANES = 4;

    // one stored frame word, lane 0 in the low byte
    typedef struct packed {
        logic [8*LANES-1:0] data;
        logic [LANES-1:0]   keep;
        logic               last;
    } rx_beat_t;

    // end of frame as seen by the decoder
    typedef struct packed {
        logic done;
        logic code_err;
        logic len_err;
    } frame_end_t;

    // exactly one of commit and discard at frame end
    typedef struct packed {
        logic commit;
        logic discard;
        logic crc_bad;
    } frame_verdict_t;

endpackage

// File: verilog/xgmii_decoder.sv
`timescale 1ns/10ps

module xgmii_decoder (
    input  logic                   rx_clk,
    input  logic                   rx_rst,
    input  logic [31:0]            in_xgmii_data,
    input  logic [3:0]             in_xgmii_ctl,
    output rx_mac_pkg::rx_beat_t   beat,
    output logic                   beat_valid,
    output rx_mac_pkg::frame_end_t frame_end
);
    import rx_mac_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_DATA
    } state_t;

    state_t      state;
    logic [31:0] hold_data;
    logic [3:0]  hold_keep;
    logic        hold_valid;
    logic        tail_pend;
    logic        tail_code_err;
    logic        tail_len_err;
    logic [10:0] byte_cnt;
    logic        code_seen;

    logic [2:0]  term_lane;
    logic [3:0]  term_keep;
    logic [3:0]  ctl_before;
    logic [11:0] total_len;
    logic        len_bad;
    logic        word_err;
    logic        is_start;
    logic        start_ok;
    logic        sfd_ok;

    // lowest terminate lane, LANES when the word has none
    always_comb begin
        term_lane = 3'(LANES);
        for (int i = LANES - 1; i >= 0; i--) begin
            if (in_xgmii_ctl[i] && in_xgmii_data[8*i +: 8] == XGMII_TERMINATE) begin
                term_lane = 3'(i);
            end
        end
        for (int i = 0; i < LANES; i++) begin
            ctl_before[i] = in_xgmii_ctl[i] && (3'(i) < term_lane);
        end
    end

    assign term_keep = (4'b0001 << term_lane) - 4'd1;
    // any control byte inside the frame is a code error
    assign word_err  = |ctl_before;
    assign total_len = {1'b0, byte_cnt} + 12'(term_lane);
    assign len_bad   = (total_len < 12'(MIN_FRAME_SIZE)) || (total_len > 12'(MAX_FRAME_SIZE));

    assign is_start = in_xgmii_ctl[0] && in_xgmii_data[7:0] == XGMII_START;
    assign start_ok = is_start && in_xgmii_ctl[3:1] == 3'b000 &&
                      in_xgmii_data[15:8] == PREAMBLE_BYTE &&
                      in_xgmii_data[23:16] == PREAMBLE_BYTE &&
                      in_xgmii_data[31:24] == PREAMBLE_BYTE;
    assign sfd_ok   = in_xgmii_ctl == 4'b0000 &&
                      in_xgmii_data[23:0] == {3{PREAMBLE_BYTE}} &&
                      in_xgmii_data[31:24] == SFD_BYTE;

    always_ff @(posedge rx_clk) begin
        if (!rx_rst) begin
            state      <= ST_IDLE;
            hold_valid <= 1'b0;
            tail_pend  <= 1'b0;
            byte_cnt   <= '0;
            code_seen  <= 1'b0;
            beat_valid <= 1'b0;
            frame_end  <= '0;
        end else begin
            beat_valid <= 1'b0;
            frame_end  <= '0;
            // partial terminate word held back behind the last full word
            if (tail_pend) begin
                tail_pend          <= 1'b0;
                beat_valid         <= 1'b1;
                beat               <= '{data: hold_data, keep: hold_keep, last: 1'b1};
                frame_end.done     <= 1'b1;
                frame_end.code_err <= tail_code_err;
                frame_end.len_err  <= tail_len_err;
            end
            case (state)
                ST_IDLE: begin
                    if (start_ok) begin
                        state <= ST_PREAMBLE;
                    end else if (is_start && !tail_pend) begin
                        frame_end.done     <= 1'b1;
                        frame_end.code_err <= 1'b1;
                    end
                end
                ST_PREAMBLE: begin
                    byte_cnt   <= '0;
                    code_seen  <= 1'b0;
                    hold_valid <= 1'b0;
                    hold_keep  <= 4'hF;
                    if (sfd_ok) begin
                        state <= ST_DATA;
                    end else begin
                        state              <= ST_IDLE;
                        frame_end.done     <= 1'b1;
                        frame_end.code_err <= 1'b1;
                    end
                end
                ST_DATA: begin
                    if (term_lane == 3'(LANES)) begin
                        byte_cnt   <= (byte_cnt > 11'd2043) ? 11'd2047 : byte_cnt + 11'd4;
                        code_seen  <= code_seen | word_err;
                        hold_data  <= in_xgmii_data;
                        hold_keep  <= 4'hF;
                        hold_valid <= 1'b1;
                        beat_valid <= hold_valid;
                        beat       <= '{data: hold_data, keep: hold_keep, last: 1'b0};
                    end else begin
                        state <= ST_IDLE;
                        if (term_lane == 3'd0 || !hold_valid) begin
                            // one beat closes the frame right away
                            beat_valid         <= hold_valid || term_lane != 3'd0;
                            frame_end.done     <= 1'b1;
                            frame_end.code_err <= code_seen | word_err;
                            frame_end.len_err  <= len_bad;
                            if (hold_valid) begin
                                beat <= '{data: hold_data, keep: hold_keep, last: 1'b1};
                            end else begin
                                beat <= '{data: in_xgmii_data, keep: term_keep, last: 1'b1};
                            end
                        end else begin
                            beat_valid    <= 1'b1;
                            beat          <= '{data: hold_data, keep: hold_keep, last: 1'b0};
                            hold_data     <= in_xgmii_data;
                            hold_keep     <= term_keep;
                            tail_pend     <= 1'b1;
                            tail_code_err <= code_seen | word_err;
                            tail_len_err  <= len_bad;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule
